//--- logic/lat_chan_pkg.sv
package lat_chan_pkg;

   //////////////////////////////////////////////////////////////
   // virtual channel codes
   //////////////////////////////////////////////////////////////
   localparam int VC_W = 2;
   // VA lets the channel pick a lane
   localparam logic [VC_W-1:0] VC_VA  = 2'd0;
   localparam logic [VC_W-1:0] VC_VL0 = 2'd1;
   localparam logic [VC_W-1:0] VC_VH0 = 2'd2;
   localparam logic [VC_W-1:0] VC_VH1 = 2'd3;
   // one low latency lane, two high latency lanes
   localparam int NUM_LANES = 3;

   // request and response types
   localparam logic REQ_RDLINE = 1'b0;
   localparam logic REQ_WRLINE = 1'b1;
   localparam logic RSP_RD     = 1'b0;
   localparam logic RSP_WR     = 1'b1;

   // field widths
   // len of L means L+1 cache lines
   localparam int LEN_W   = 2;
   localparam int ADDR_W  = 16;
   localparam int MDATA_W = 12;
   localparam int DATA_W  = 32;

   //////////////////////////////////////////////////////////////
   // record word {vc, type, len, addr, mdata, data}
   //////////////////////////////////////////////////////////////
   localparam int REC_MDATA_LSB = DATA_W;
   localparam int REC_ADDR_LSB  = REC_MDATA_LSB + MDATA_W;
   localparam int REC_LEN_LSB   = REC_ADDR_LSB + ADDR_W;
   localparam int REC_TYPE_LSB  = REC_LEN_LSB + LEN_W;
   localparam int REC_VC_LSB    = REC_TYPE_LSB + 1;
   localparam int REC_W         = REC_VC_LSB + VC_W;

   // response word {vc, rsptype, clnum, addr, mdata, data}
   localparam int RSP_W = VC_W + 1 + LEN_W + ADDR_W + MDATA_W + DATA_W;

   // station countdown width, bounds MAX_DELAY
   localparam int CNT_W = 8;

endpackage

//--- logic/chan_fifo.sv
`timescale 1ns/1ps

module chan_fifo #(
   parameter int DEPTH          = 16,
   parameter int WIDTH          = 8,
   parameter int ALMFULL_THRESH = 12
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             push_i,
   input  logic [WIDTH-1:0] push_data_i,
   input  logic             pop_i,
   output logic [WIDTH-1:0] pop_data_o,
   output logic             empty_o,
   output logic             almfull_o
);

   localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int FILL_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0]  mem [DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [FILL_W-1:0] fill;

   // wrap at DEPTH, which need not be a power of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   // storage
   always_ff @(posedge clk) begin
      if (push_i) begin
         mem[wr_ptr] <= push_data_i;
      end
   end

   // pointers and fill level
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (push_i) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop_i) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({push_i, pop_i})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
      end
   end

   // head shown ahead of the pop
   assign pop_data_o = mem[rd_ptr];
   assign empty_o    = (fill == '0);
   assign almfull_o  = (fill > FILL_W'(ALMFULL_THRESH));

   a_no_overflow : assert property (@(posedge clk) disable iff (rst)
      push_i |-> (fill != FILL_W'(DEPTH)));
   a_no_underflow : assert property (@(posedge clk) disable iff (rst)
      pop_i |-> !empty_o);

endmodule

//--- logic/vc_steer.sv
`timescale 1ns/1ps

module vc_steer import lat_chan_pkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  logic [REC_W-1:0]     head_i,
   input  logic                 head_valid_i,
   input  logic [NUM_LANES-1:0] lane_full_i,
   output logic                 pop_o,
   output logic [NUM_LANES-1:0] lane_push_o,
   output logic [REC_W-1:0]     rec_o
);

   logic [VC_W-1:0]      req_vc;
   logic [VC_W-1:0]      sel_vc;
   logic [VC_W-1:0]      last_vc;
   logic [NUM_LANES-1:0] lane_sel;
   logic                 go;

   assign req_vc = head_i[REC_VC_LSB +: VC_W];

   //////////////////////////////////////////////////////////////
   // lane resolution
   //////////////////////////////////////////////////////////////
   always_comb begin
      sel_vc = req_vc;
      if (req_vc == VC_VA) begin
         // pattern is {vl0, vh0, vh1} full
         case ({lane_full_i[0], lane_full_i[1], lane_full_i[2]})
            3'b000: begin
               // all open, rotate from last pick
               case (last_vc)
                  VC_VL0:  sel_vc = VC_VH0;
                  VC_VH0:  sel_vc = VC_VH1;
                  default: sel_vc = VC_VL0;
               endcase
            end
            3'b001, 3'b011: sel_vc = VC_VL0;
            3'b010, 3'b110: sel_vc = VC_VH1;
            3'b100, 3'b101: sel_vc = VC_VH0;
            // every lane full, hold the request
            default: sel_vc = VC_VA;
         endcase
      end
   end

   // lane i carries code i+1
   always_comb begin
      for (int i = 0; i < NUM_LANES; i++) begin
         lane_sel[i] = (sel_vc == VC_W'(i + 1));
      end
   end

   // explicit lane that is full stalls the head
   assign go          = head_valid_i && (|lane_sel) && !(|(lane_sel & lane_full_i));
   assign pop_o       = go;
   assign lane_push_o = go ? lane_sel : '0;

   // chosen code written back into the record
   always_comb begin
      rec_o                          = head_i;
      rec_o[REC_VC_LSB +: VC_W]      = sel_vc;
   end

   // only VA picks move the rotation
   always_ff @(posedge clk) begin
      if (rst) begin
         last_vc <= VC_VA;
      end else if (go && (req_vc == VC_VA)) begin
         last_vc <= sel_vc;
      end
   end

   a_lane_resolved : assert property (@(posedge clk) disable iff (rst)
      (|lane_push_o) |-> (rec_o[REC_VC_LSB +: VC_W] != VC_VA) && $onehot(lane_push_o));

endmodule

//--- logic/slot_alloc.sv
`timescale 1ns/1ps

module slot_alloc import lat_chan_pkg::*; #(
   parameter int NUM_WAIT_STATIONS = 8,
   parameter int MIN_DELAY         = 4,
   parameter int MAX_DELAY         = 19
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic [REC_W-1:0]             lane_head_i [NUM_LANES],
   input  logic [NUM_LANES-1:0]         lane_empty_i,
   input  logic [NUM_WAIT_STATIONS-1:0] station_busy_i,
   output logic [NUM_LANES-1:0]         lane_pop_o,
   output logic [NUM_WAIT_STATIONS-1:0] load_o,
   output logic [REC_W-1:0]             rec_o,
   output logic [CNT_W-1:0]             delay_o
);

   localparam int ST_W   = (NUM_WAIT_STATIONS > 1) ? $clog2(NUM_WAIT_STATIONS) : 1;
   localparam int LSEL_W = $clog2(NUM_LANES);
   localparam int SPAN   = MAX_DELAY - MIN_DELAY + 1;

   logic [LSEL_W-1:0] lane_sel;
   logic [ST_W-1:0]   push_ptr;
   logic [ST_W-1:0]   free_idx;
   logic              free_found;
   logic              serve;
   logic [15:0]       lfsr;
   logic [15:0]       fold;

   //////////////////////////////////////////////////////////////
   // free station search from the push pointer
   //////////////////////////////////////////////////////////////
   always_comb begin : find_free
      int idx;
      free_found = 1'b0;
      free_idx   = '0;
      for (int k = 0; k < NUM_WAIT_STATIONS; k++) begin
         idx = (int'(push_ptr) + k) % NUM_WAIT_STATIONS;
         if (!free_found && !station_busy_i[idx]) begin
            free_found = 1'b1;
            free_idx   = ST_W'(idx);
         end
      end
   end

   // current lane only, no skip ahead to another lane
   assign serve = !lane_empty_i[lane_sel] && free_found;
   assign rec_o = lane_head_i[lane_sel];

   always_comb begin
      lane_pop_o = '0;
      load_o     = '0;
      if (serve) begin
         lane_pop_o[lane_sel] = 1'b1;
         load_o[free_idx]     = 1'b1;
      end
   end

   // lfsr folded into MIN_DELAY..MAX_DELAY
   assign fold    = lfsr % 16'(SPAN);
   assign delay_o = CNT_W'(MIN_DELAY) + CNT_W'(fold);

   always_ff @(posedge clk) begin
      if (rst) begin
         lane_sel <= '0;
         push_ptr <= '0;
         lfsr     <= 16'hace1;
      end else begin
         // rotation VL0, VH0, VH1 every cycle
         lane_sel <= (lane_sel == LSEL_W'(NUM_LANES - 1)) ? '0 : lane_sel + 1'b1;
         // taps 16 14 13 11
         lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
         if (serve) begin
            push_ptr <= (free_idx == ST_W'(NUM_WAIT_STATIONS - 1)) ? '0 : free_idx + 1'b1;
         end
      end
   end

   a_load_free : assert property (@(posedge clk) disable iff (rst)
      $onehot0(load_o) && !(|(load_o & station_busy_i)));

endmodule

//--- logic/wait_station.sv
`timescale 1ns/1ps

module wait_station import lat_chan_pkg::*; (
   input  logic             clk,
   input  logic             rst,
   input  logic             load_i,
   input  logic [REC_W-1:0] rec_i,
   input  logic [CNT_W-1:0] delay_i,
   input  logic             release_i,
   output logic             busy_o,
   output logic             ready_o,
   output logic [REC_W-1:0] rec_o
);

   // station states
   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_COUNT = 2'd1;
   localparam logic [1:0] ST_READY = 2'd2;

   logic [1:0]       state;
   logic [CNT_W-1:0] cnt;
   logic [REC_W-1:0] rec_q;

   // held record
   always_ff @(posedge clk) begin
      if (load_i) begin
         rec_q <= rec_i;
      end
   end

   //////////////////////////////////////////////////////////////
   // countdown fsm, ready delay+1 cycles after load
   //////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_IDLE;
         cnt   <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (load_i) begin
                  state <= ST_COUNT;
                  cnt   <= delay_i;
               end
            end
            ST_COUNT: begin
               if (cnt == '0) begin
                  state <= ST_READY;
               end else begin
                  cnt <= cnt - 1'b1;
               end
            end
            ST_READY: begin
               // freed on the last unrolled line
               if (release_i) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   assign busy_o  = (state != ST_IDLE);
   assign ready_o = (state == ST_READY);
   assign rec_o   = rec_q;

endmodule

//--- logic/line_unroll.sv
`timescale 1ns/1ps

module line_unroll import lat_chan_pkg::*; #(
   parameter int NUM_WAIT_STATIONS = 8
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic [NUM_WAIT_STATIONS-1:0] ready_i,
   input  logic [REC_W-1:0]             recs_i [NUM_WAIT_STATIONS],
   input  logic                         out_full_i,
   output logic [NUM_WAIT_STATIONS-1:0] release_o,
   output logic                         push_o,
   output logic [RSP_W-1:0]             rsp_o
);

   localparam int ST_W = (NUM_WAIT_STATIONS > 1) ? $clog2(NUM_WAIT_STATIONS) : 1;

   logic             locked;
   logic [ST_W-1:0]  lock_idx;
   logic [ST_W-1:0]  pop_ptr;
   logic [ST_W-1:0]  hit_idx;
   logic             hit;
   logic [LEN_W-1:0] line_cnt;
   logic [REC_W-1:0] cur;
   logic             rsp_type;
   logic             last_line;
   logic             emit;

   //////////////////////////////////////////////////////////////
   // ready station search from the pop pointer
   //////////////////////////////////////////////////////////////
   always_comb begin : find_ready
      int idx;
      hit     = 1'b0;
      hit_idx = '0;
      for (int k = 0; k < NUM_WAIT_STATIONS; k++) begin
         idx = (int'(pop_ptr) + k) % NUM_WAIT_STATIONS;
         if (!hit && ready_i[idx]) begin
            hit     = 1'b1;
            hit_idx = ST_W'(idx);
         end
      end
   end

   assign cur       = recs_i[lock_idx];
   assign last_line = (line_cnt == cur[REC_LEN_LSB +: LEN_W]);
   // one line per cycle unless the output FIFO is almost full
   assign emit      = locked && !out_full_i;
   assign push_o    = emit;

   assign rsp_type = (cur[REC_TYPE_LSB] == REQ_WRLINE) ? RSP_WR : RSP_RD;

   // line word, addr stepped by clnum
   assign rsp_o = {cur[REC_VC_LSB +: VC_W],
                   rsp_type,
                   line_cnt,
                   cur[REC_ADDR_LSB +: ADDR_W] + ADDR_W'(line_cnt),
                   cur[REC_MDATA_LSB +: MDATA_W],
                   cur[DATA_W-1:0]};

   always_comb begin
      release_o = '0;
      if (emit && last_line) begin
         release_o[lock_idx] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         locked   <= 1'b0;
         lock_idx <= '0;
         pop_ptr  <= '0;
         line_cnt <= '0;
      end else if (!locked) begin
         if (hit) begin
            locked   <= 1'b1;
            lock_idx <= hit_idx;
            line_cnt <= '0;
         end
      end else if (emit) begin
         if (last_line) begin
            locked  <= 1'b0;
            // next search starts past this station
            pop_ptr <= (lock_idx == ST_W'(NUM_WAIT_STATIONS - 1)) ? '0 : lock_idx + 1'b1;
         end else begin
            line_cnt <= line_cnt + 1'b1;
         end
      end
   end

   a_release_locked : assert property (@(posedge clk) disable iff (rst)
      (|release_o) |-> locked && $onehot(release_o) && |(release_o & ready_i));

endmodule

//--- logic/lat_chan_top.sv
`timescale 1ns/1ps

module lat_chan_top import lat_chan_pkg::*; #(
   parameter int NUM_WAIT_STATIONS   = 8,
   parameter int VISIBLE_DEPTH_BASE2 = 4,
   parameter int VISIBLE_FULL_THRESH = 12,
   parameter int LANE_DEPTH          = 4,
   parameter int MIN_DELAY           = 4,
   parameter int MAX_DELAY           = 19
) (
   input  logic               clk,
   input  logic               rst,
   // write side
   input  logic               wr_en_i,
   input  logic [VC_W-1:0]    req_vc_i,
   input  logic               req_type_i,
   input  logic [LEN_W-1:0]   req_len_i,
   input  logic [ADDR_W-1:0]  req_addr_i,
   input  logic [MDATA_W-1:0] req_mdata_i,
   input  logic [DATA_W-1:0]  req_data_i,
   output logic               full_o,
   // read side
   input  logic               rd_en_i,
   output logic               empty_o,
   output logic               valid_o,
   output logic [VC_W-1:0]    rsp_vc_o,
   output logic               rsp_type_o,
   output logic [LEN_W-1:0]   rsp_clnum_o,
   output logic [ADDR_W-1:0]  rsp_addr_o,
   output logic [MDATA_W-1:0] rsp_mdata_o,
   output logic [DATA_W-1:0]  rsp_data_o
);

   localparam int VISIBLE_DEPTH = 2**VISIBLE_DEPTH_BASE2;

   // input staging
   logic [REC_W-1:0]             in_rec;
   logic [REC_W-1:0]             in_head;
   logic                         in_empty;
   logic                         in_almfull;
   logic                         in_pop;
   // lanes
   logic [NUM_LANES-1:0]         lane_push;
   logic [NUM_LANES-1:0]         lane_pop;
   logic [NUM_LANES-1:0]         lane_full;
   logic [NUM_LANES-1:0]         lane_empty;
   logic [REC_W-1:0]             lane_head [NUM_LANES];
   logic [REC_W-1:0]             steer_rec;
   // stations
   logic [NUM_WAIT_STATIONS-1:0] st_load;
   logic [NUM_WAIT_STATIONS-1:0] st_busy;
   logic [NUM_WAIT_STATIONS-1:0] st_ready;
   logic [NUM_WAIT_STATIONS-1:0] st_release;
   logic [REC_W-1:0]             st_rec [NUM_WAIT_STATIONS];
   logic [REC_W-1:0]             alloc_rec;
   logic [CNT_W-1:0]             alloc_delay;
   // output
   logic                         out_push;
   logic [RSP_W-1:0]             out_rsp;
   logic [RSP_W-1:0]             out_head;
   logic                         out_empty;
   logic                         out_almfull;
   logic                         out_pop;

   //////////////////////////////////////////////////////////////
   // request staging and steering
   //////////////////////////////////////////////////////////////
   assign in_rec = {req_vc_i, req_type_i, req_len_i, req_addr_i, req_mdata_i, req_data_i};

   chan_fifo #(
      .DEPTH(VISIBLE_DEPTH), .WIDTH(REC_W), .ALMFULL_THRESH(VISIBLE_FULL_THRESH)
   ) u_infifo (
      .clk, .rst, .push_i(wr_en_i), .push_data_i(in_rec), .pop_i(in_pop),
      .pop_data_o(in_head), .empty_o(in_empty), .almfull_o(in_almfull)
   );

   // full held high through reset
   always_ff @(posedge clk) begin
      if (rst) begin
         full_o <= 1'b1;
      end else begin
         full_o <= in_almfull;
      end
   end

   vc_steer u_steer (
      .clk, .rst, .head_i(in_head), .head_valid_i(!in_empty), .lane_full_i(lane_full),
      .pop_o(in_pop), .lane_push_o(lane_push), .rec_o(steer_rec)
   );

   // lane full means no free entry left
   for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
      chan_fifo #(
         .DEPTH(LANE_DEPTH), .WIDTH(REC_W), .ALMFULL_THRESH(LANE_DEPTH - 1)
      ) u_lane (
         .clk, .rst, .push_i(lane_push[g]), .push_data_i(steer_rec), .pop_i(lane_pop[g]),
         .pop_data_o(lane_head[g]), .empty_o(lane_empty[g]), .almfull_o(lane_full[g])
      );
   end

   //////////////////////////////////////////////////////////////
   // wait stations
   //////////////////////////////////////////////////////////////
   slot_alloc #(
      .NUM_WAIT_STATIONS(NUM_WAIT_STATIONS), .MIN_DELAY(MIN_DELAY), .MAX_DELAY(MAX_DELAY)
   ) u_alloc (
      .clk, .rst, .lane_head_i(lane_head), .lane_empty_i(lane_empty),
      .station_busy_i(st_busy), .lane_pop_o(lane_pop), .load_o(st_load),
      .rec_o(alloc_rec), .delay_o(alloc_delay)
   );

   for (genvar s = 0; s < NUM_WAIT_STATIONS; s++) begin : g_station
      wait_station u_station (
         .clk, .rst, .load_i(st_load[s]), .rec_i(alloc_rec), .delay_i(alloc_delay),
         .release_i(st_release[s]), .busy_o(st_busy[s]), .ready_o(st_ready[s]),
         .rec_o(st_rec[s])
      );
   end

   line_unroll #(
      .NUM_WAIT_STATIONS(NUM_WAIT_STATIONS)
   ) u_unroll (
      .clk, .rst, .ready_i(st_ready), .recs_i(st_rec), .out_full_i(out_almfull),
      .release_o(st_release), .push_o(out_push), .rsp_o(out_rsp)
   );

   //////////////////////////////////////////////////////////////
   // output FIFO and read port
   //////////////////////////////////////////////////////////////
   chan_fifo #(
      .DEPTH(VISIBLE_DEPTH), .WIDTH(RSP_W), .ALMFULL_THRESH(VISIBLE_FULL_THRESH)
   ) u_outfifo (
      .clk, .rst, .push_i(out_push), .push_data_i(out_rsp), .pop_i(out_pop),
      .pop_data_o(out_head), .empty_o(out_empty), .almfull_o(out_almfull)
   );

   // read enable ignored while empty
   assign out_pop = rd_en_i && !out_empty;
   assign empty_o = out_empty;

   always_ff @(posedge clk) begin
      if (rst) begin
         valid_o <= 1'b0;
      end else begin
         valid_o <= out_pop;
      end
   end

   // response fields follow the popped line
   always_ff @(posedge clk) begin
      if (out_pop) begin
         {rsp_vc_o, rsp_type_o, rsp_clnum_o, rsp_addr_o, rsp_mdata_o, rsp_data_o} <= out_head;
      end
   end

endmodule

//--- bench/tb_lat_chan.sv
`timescale 1ns/1ps

module tb_lat_chan import lat_chan_pkg::*; ();

   localparam int MIN_DELAY      = 4;
   localparam int MAX_DELAY      = 19;
   localparam int NUM_REQ        = 60;
   localparam int STALL_AFTER    = 20;
   localparam int STALL_CYCLES   = 200;
   localparam int TIMEOUT_CYCLES = NUM_REQ * (MAX_DELAY + 12) + 400;

   logic               clk = 1'b0;
   logic               rst;
   logic               wr_en_i;
   logic [VC_W-1:0]    req_vc_i;
   logic               req_type_i;
   logic [LEN_W-1:0]   req_len_i;
   logic [ADDR_W-1:0]  req_addr_i;
   logic [MDATA_W-1:0] req_mdata_i;
   logic [DATA_W-1:0]  req_data_i;
   logic               full_o;
   logic               rd_en_i;
   logic               empty_o;
   logic               valid_o;
   logic [VC_W-1:0]    rsp_vc_o;
   logic               rsp_type_o;
   logic [LEN_W-1:0]   rsp_clnum_o;
   logic [ADDR_W-1:0]  rsp_addr_o;
   logic [MDATA_W-1:0] rsp_mdata_o;
   logic [DATA_W-1:0]  rsp_data_o;

   // expected fields per mdata
   logic [VC_W-1:0]    exp_vc   [int];
   logic               exp_type [int];
   logic [LEN_W-1:0]   exp_len  [int];
   logic [ADDR_W-1:0]  exp_addr [int];
   logic [DATA_W-1:0]  exp_data [int];
   int unsigned        acc_cyc  [int];
   bit                 started  [int];

   int unsigned cyc         = 0;
   int          accepted    = 0;
   int          total_lines = 0;
   int          lines_seen  = 0;
   int          done_cnt    = 0;
   int          errors      = 0;
   // request currently being unrolled on the read side
   bit          in_line     = 1'b0;
   int          cur_m       = 0;
   int          next_cl     = 0;

   lat_chan_top #(
      .MIN_DELAY(MIN_DELAY), .MAX_DELAY(MAX_DELAY)
   ) DUT (.*);

   always #5 clk = ~clk;

   always @(posedge clk) cyc <= cyc + 1;

   task automatic check_field(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp) else begin
         errors++;
         $display("ERROR at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      end
   endtask

   task automatic flag_error(input string msg);
      errors++;
      $display("ERROR at %0t: %s", $time, msg);
   endtask

   task automatic print_summary();
      $display("errors: %0d, accepted: %0d, answered: %0d, lines read: %0d of %0d",
               errors, accepted, done_cnt, lines_seen, total_lines);
   endtask

   ////////////////////////////////////////////////////////////
   // protocol assertions on the read port
   ////////////////////////////////////////////////////////////
   a_pop_gives_valid : assert property (@(posedge clk) disable iff (rst)
      (rd_en_i && !empty_o) |=> valid_o)
      else flag_error("valid_o did not follow an accepted read");
   a_no_stray_valid : assert property (@(posedge clk) disable iff (rst)
      (!rd_en_i || empty_o) |=> !valid_o)
      else flag_error("valid_o rose without an accepted read");
   // VA never leaks out
   a_lane_resolved : assert property (@(posedge clk) disable iff (rst)
      valid_o |-> (rsp_vc_o != VC_VA))
      else flag_error("response line still carries the any-lane code");

   // accepted writes into the reference tables
   always @(posedge clk) begin : record_writes
      int m;
      if (!rst && wr_en_i) begin
         m = int'(req_mdata_i);
         exp_vc[m]   = req_vc_i;
         exp_type[m] = req_type_i;
         exp_len[m]  = req_len_i;
         exp_addr[m] = req_addr_i;
         exp_data[m] = req_data_i;
         acc_cyc[m]  = cyc;
         accepted    <= accepted + 1;
         total_lines <= total_lines + int'(req_len_i) + 1;
      end
   end

   ////////////////////////////////////////////////////////////
   // response line checks
   ////////////////////////////////////////////////////////////
   always @(posedge clk) begin : check_lines
      int m;
      int cl;
      if (!rst && accepted == 0) begin
         assert (empty_o === 1'b1 && valid_o === 1'b0)
            else flag_error("read side not idle before the first request");
      end
      if (!rst && valid_o) begin
         m = int'(rsp_mdata_o);
         // line number this line should carry
         cl = in_line ? next_cl : 0;
         lines_seen <= lines_seen + 1;
         if (!exp_len.exists(m)) begin
            flag_error("response line carries an mdata that was never written");
         end else begin
            if (in_line) begin
               // lines of one request stay together
               check_field("rsp_mdata_o", 64'(rsp_mdata_o), 64'(cur_m));
            end else begin
               assert (!started.exists(m)) else flag_error("request answered twice");
               assert (int'(cyc - acc_cyc[m]) >= MIN_DELAY + 4)
                  else flag_error("first line arrived sooner than the minimum latency");
               started[m] = 1'b1;
            end
            check_field("rsp_clnum_o", 64'(rsp_clnum_o), 64'(cl));
            check_field("rsp_type_o", 64'(rsp_type_o),
                        (exp_type[m] == REQ_WRLINE) ? 64'(RSP_WR) : 64'(RSP_RD));
            check_field("rsp_addr_o", 64'(rsp_addr_o),
                        64'(exp_addr[m] + ADDR_W'(cl)));
            check_field("rsp_data_o", 64'(rsp_data_o), 64'(exp_data[m]));
            // explicit lane comes back unchanged
            if (exp_vc[m] != VC_VA) begin
               check_field("rsp_vc_o", 64'(rsp_vc_o), 64'(exp_vc[m]));
            end
            if (cl >= int'(exp_len[m])) begin
               in_line  = 1'b0;
               done_cnt <= done_cnt + 1;
            end else begin
               in_line = 1'b1;
               cur_m   = m;
               next_cl = cl + 1;
            end
         end
      end
   end

   // reader with random gaps and one long stall
   initial begin : reader
      int stall_left;
      bit stall_done;
      stall_left = 0;
      stall_done = 1'b0;
      wait (rst == 1'b0);
      forever begin
         @(posedge clk);
         if (!stall_done && accepted >= STALL_AFTER) begin
            stall_left = STALL_CYCLES;
            stall_done = 1'b1;
         end
         if (stall_left > 0) begin
            rd_en_i <= 1'b0;
            stall_left--;
         end else begin
            rd_en_i <= (($urandom % 4) != 0);
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////
   initial begin : main
      int n;
      void'($urandom(67458));
      rst         = 1'b1;
      wr_en_i     = 1'b0;
      req_vc_i    = '0;
      req_type_i  = 1'b0;
      req_len_i   = '0;
      req_addr_i  = '0;
      req_mdata_i = '0;
      req_data_i  = '0;
      rd_en_i     = 1'b0;
      repeat (5) @(posedge clk);
      // full held through reset, drops a cycle after release
      check_field("full_o", 64'(full_o), 64'd1);
      rst <= 1'b0;
      repeat (2) @(posedge clk);
      check_field("full_o", 64'(full_o), 64'd0);

      n = 0;
      while (n < NUM_REQ) begin
         @(posedge clk);
         if (!full_o && (($urandom % 4) != 0)) begin
            wr_en_i     <= 1'b1;
            req_vc_i    <= VC_W'($urandom);
            req_type_i  <= 1'($urandom);
            req_len_i   <= LEN_W'($urandom);
            req_addr_i  <= ADDR_W'($urandom);
            req_mdata_i <= MDATA_W'(256 + n);
            req_data_i  <= $urandom;
            n++;
         end else begin
            wr_en_i <= 1'b0;
         end
      end
      @(posedge clk);
      wr_en_i <= 1'b0;

      while (done_cnt < NUM_REQ) begin
         @(posedge clk);
      end
      // quiet period, nothing extra may come out
      repeat (40) @(posedge clk);
      check_field("empty_o", 64'(empty_o), 64'd1);
      assert (lines_seen == total_lines)
         else flag_error("line count does not match the requests");
      print_summary();
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   initial begin : watchdog
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("timeout: not all requests were answered within %0d cycles", TIMEOUT_CYCLES);
      print_summary();
      $display("Result: FAILED");
      $finish;
   end

endmodule

//--- src.f
logic/lat_chan_pkg.sv
logic/chan_fifo.sv
logic/vc_steer.sv
logic/slot_alloc.sv
logic/wait_station.sv
logic/line_unroll.sv
logic/lat_chan_top.sv
bench/tb_lat_chan.sv

//--- run.sh
#!/bin/sh
# build and run the latency channel testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_lat_chan -o sim_lat_chan

obj_dir/sim_lat_chan | tee sim.log

# pass only when the testbench printed its pass line
grep -q "^Result: PASSED$" sim.log
